//--- filelist.f
+incdir+.
i3c_bus_pkg.sv
target_regs_pkg.sv
reg_access_if.sv
i3c_target_fsm.sv
target_register_bank.sv
i3c_target_top.sv
i3c_target_tb.sv

//--- i3c_bus_pkg.sv
// bus-side types of the I3C target, imported by the frame engine and the testbench
`default_nettype none

package i3c_bus_pkg;

  // **********************************************************************
  // frame phases
  // **********************************************************************

  typedef enum logic [2:0] {
    PH_IDLE     = 3'd0,  // waiting for sda low
    PH_ADDR     = 3'd1,  // 7 address bits + rnw
    PH_ADDR_ACK = 3'd2,  // target pulls sda low on match
    PH_WRITE    = 3'd3,  // controller sends a byte
    PH_READ     = 3'd4,  // target sends a byte
    PH_TBIT     = 3'd5   // 0 = more bytes, 1 = end of frame
  } frame_phase_t;

  // **********************************************************************
  // payload
  // **********************************************************************

  // one byte as it travels on sda, msb first
  typedef logic [7:0] bus_byte_t;

endpackage

`default_nettype wire

//--- i3c_target_config.svh
// build options for the I3C target, `included by any file that needs the address or register count
`ifndef I3C_TARGET_CONFIG_SVH
`define I3C_TARGET_CONFIG_SVH

// **********************************************************************
// bus identity
// **********************************************************************

// static 7-bit address the target answers to
`define I3C_TARGET_ADDR 7'h27

// **********************************************************************
// register bank
// **********************************************************************

// must stay a power of two so the pointer wraps on its own
`define I3C_REG_COUNT 16

`endif

//--- i3c_target_fsm.sv
// I3C target frame engine: start, address, ack, data bytes and T-bit, used inside i3c_target_top
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_config.svh"

module i3c_target_fsm (
  input  logic                   scl,
  input  logic                   reset_n,
  input  logic                   sda_i,
  output logic                   sda_drive_low,
  output logic                   busy,
  output i3c_bus_pkg::bus_byte_t rx_data,
  output logic                   rx_valid,
  reg_access_if.engine           regs
);
  import i3c_bus_pkg::*;
  import target_regs_pkg::*;

  localparam logic [6:0] OWN_ADDR = `I3C_TARGET_ADDR;

  frame_phase_t state_q;
  bus_byte_t    shift_q;
  logic [2:0]   bit_cnt_q;
  logic         rnw_q;         // 1 = read frame
  logic         addr_ok_q;
  logic         first_byte_q;  // next write byte is the pointer

  bus_byte_t    shift_in;
  logic         last_bit;
  logic         load_tx;

  assign shift_in = {shift_q[6:0], sda_i};
  assign last_bit = (bit_cnt_q == 3'd7);

  // fetch the next read byte at the end of the ack slot or after a T-bit of 0
  assign load_tx = rnw_q &&
                   (((state_q == PH_ADDR_ACK) && addr_ok_q) ||
                    ((state_q == PH_TBIT) && !sda_i));

  assign regs.wdata = reg_word_t'(rx_data);

  // **********************************************************************
  // frame sequencing, rising edge
  // **********************************************************************

  always_ff @(posedge scl or negedge reset_n) begin
    if (!reset_n) begin
      state_q       <= PH_IDLE;
      bit_cnt_q     <= 3'd0;
      rnw_q         <= 1'b0;
      addr_ok_q     <= 1'b0;
      first_byte_q  <= 1'b0;
      busy          <= 1'b0;
      rx_valid      <= 1'b0;
      regs.ptr_load <= 1'b0;
      regs.wr_en    <= 1'b0;
      regs.rd_next  <= 1'b0;
    end else begin
      rx_valid      <= 1'b0;
      regs.ptr_load <= 1'b0;
      regs.wr_en    <= 1'b0;
      regs.rd_next  <= load_tx;

      case (state_q)
        PH_IDLE: begin
          if (!sda_i) begin  // start
            state_q   <= PH_ADDR;
            bit_cnt_q <= 3'd0;
          end
        end

        PH_ADDR: begin
          busy      <= 1'b1;
          bit_cnt_q <= bit_cnt_q + 3'd1;
          if (last_bit) begin
            rnw_q     <= sda_i;
            addr_ok_q <= (shift_q[6:0] == OWN_ADDR);
            state_q   <= PH_ADDR_ACK;
          end
        end

        PH_ADDR_ACK: begin
          bit_cnt_q <= 3'd0;
          if (!addr_ok_q) begin  // not ours
            state_q <= PH_IDLE;
            busy    <= 1'b0;
          end else if (rnw_q) begin
            state_q <= PH_READ;
          end else begin
            state_q      <= PH_WRITE;
            first_byte_q <= 1'b1;
          end
        end

        PH_WRITE: begin
          bit_cnt_q <= bit_cnt_q + 3'd1;
          if (last_bit) begin
            rx_valid      <= 1'b1;
            regs.ptr_load <= first_byte_q;
            regs.wr_en    <= !first_byte_q;
            first_byte_q  <= 1'b0;
            state_q       <= PH_TBIT;
          end
        end

        PH_READ: begin
          bit_cnt_q <= bit_cnt_q + 3'd1;
          if (last_bit) state_q <= PH_TBIT;
        end

        PH_TBIT: begin
          bit_cnt_q <= 3'd0;
          if (sda_i) begin  // last byte
            state_q <= PH_IDLE;
            busy    <= 1'b0;
          end else if (rnw_q) begin
            state_q <= PH_READ;
          end else begin
            state_q <= PH_WRITE;
          end
        end

        default: state_q <= PH_IDLE;
      endcase
    end
  end

  // **********************************************************************
  // data path, rising edge
  // **********************************************************************

  always_ff @(posedge scl) begin
    case (state_q)
      PH_ADDR, PH_WRITE: shift_q <= shift_in;
      PH_READ:           shift_q <= {shift_q[6:0], 1'b0};  // next bit to msb
      default: begin
        if (load_tx) shift_q <= bus_byte_t'(regs.rdata);
      end
    endcase

    if ((state_q == PH_WRITE) && last_bit) begin
      rx_data <= shift_in;  // held until the next byte
    end
  end

  // **********************************************************************
  // sda drive, falling edge only
  // **********************************************************************

  always_ff @(negedge scl or negedge reset_n) begin
    if (!reset_n) begin
      sda_drive_low <= 1'b0;
    end else begin
      case (state_q)
        PH_ADDR_ACK: sda_drive_low <= addr_ok_q;
        PH_READ:     sda_drive_low <= ~shift_q[7];
        default:     sda_drive_low <= 1'b0;  // released for T-bit and writes
      endcase
    end
  end

  // line must be free whenever no frame is running
  a_idle_released: assert property (
    @(posedge scl) disable iff (!reset_n)
    ((state_q == PH_IDLE) || !busy) |-> !sda_drive_low
  );

  // at most one bank strobe per edge
  a_one_strobe: assert property (
    @(posedge scl) disable iff (!reset_n)
    $onehot0({regs.ptr_load, regs.wr_en, regs.rd_next})
  );

  a_rx_valid_pulse: assert property (
    @(posedge scl) disable iff (!reset_n)
    rx_valid |=> !rx_valid
  );

endmodule

`default_nettype wire

//--- i3c_target_tb.sv
// testbench for the I3C target, plays the bus controller and checks every frame against a register model
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_config.svh"

module i3c_target_tb;
  import i3c_bus_pkg::*;

  localparam logic [6:0] OWN_ADDR = `I3C_TARGET_ADDR;
  localparam int REG_COUNT = `I3C_REG_COUNT;
  localparam int NUM_FRAMES = 53;
  // start, address, ack, 18 bytes of 9 bits, idle gap
  localparam int MAX_FRAME_CYCLES = 1 + 8 + 1 + 18 * 9 + 2;
  localparam int CYCLE_LIMIT = NUM_FRAMES * MAX_FRAME_CYCLES + 200;

  logic      scl;
  logic      reset_n;
  logic      sda_ctrl;  // controller side of the open-drain line
  logic      sda_bus;
  logic      sda_drive_low;
  logic      busy;
  bus_byte_t rx_data;
  logic      rx_valid;

  assign sda_bus = sda_ctrl & ~sda_drive_low;  // wired AND with pull-up

  i3c_target_top DUT (
    .scl           (scl),
    .reset_n       (reset_n),
    .sda_i         (sda_bus),
    .sda_drive_low (sda_drive_low),
    .busy          (busy),
    .rx_data       (rx_data),
    .rx_valid      (rx_valid)
  );

  // **********************************************************************
  // reference model and bookkeeping
  // **********************************************************************

  bus_byte_t model_regs [REG_COUNT];
  int        model_ptr;
  bus_byte_t frame_buf [18];  // bytes of the next write frame

  int error_count = 0;
  int check_count = 0;
  int test_count = 0;
  int errors_before = 0;
  int cycle_count = 0;

  initial begin
    scl = 1'b0;
    forever #5 scl = ~scl;
  end

  always @(posedge scl) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: run still going after %0d scl cycles", cycle_count);
      $display("Testbench failed");
      $finish;
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Error at %0t: %s: got 0x%0h, expected 0x%0h", $time, what, actual, expected);
    end
  endtask

  task automatic report_test(input string name);
    test_count++;
    $display("test %0d (%s) done, %0d errors", test_count, name, error_count - errors_before);
    errors_before = error_count;
  endtask

  function automatic logic [6:0] wrong_address();
    logic [6:0] a;
    a = 7'($urandom);
    while (a == OWN_ADDR) a = 7'($urandom);
    return a;
  endfunction

  task automatic fill_frame(input bus_byte_t ptr_byte, input int nbytes);
    frame_buf[0] = ptr_byte;
    for (int i = 1; i < nbytes; i++) begin
      frame_buf[i] = bus_byte_t'($urandom);
    end
  endtask

  // **********************************************************************
  // controller side of the bus
  // **********************************************************************

  task automatic send_start();
    @(negedge scl);
    sda_ctrl = 1'b0;  // sampled low while idle
  endtask

  task automatic send_address(input logic [6:0] addr, input logic rnw, input logic expect_ack);
    for (int i = 6; i >= 0; i--) begin
      @(negedge scl);
      sda_ctrl = addr[i];
    end
    @(negedge scl);
    sda_ctrl = rnw;
    @(negedge scl);
    sda_ctrl = 1'b1;  // release for the ack slot
    check_value(busy, 1'b1, "busy during address");
    @(posedge scl);
    check_value(sda_drive_low, expect_ack, "address acknowledge");
  endtask

  task automatic write_byte(input bus_byte_t data, input logic last);
    for (int i = 7; i >= 0; i--) begin
      @(negedge scl);
      check_value(rx_valid, 1'b0, "rx_valid inside a byte");
      check_value(busy, 1'b1, "busy during write byte");
      sda_ctrl = data[i];
      @(posedge scl);
      check_value(sda_drive_low, 1'b0, "target drives sda in a write bit");
    end
    @(negedge scl);
    check_value(rx_valid, 1'b1, "rx_valid after last bit");
    check_value(rx_data, data, "rx_data");
    sda_ctrl = last;  // T-bit
    @(posedge scl);
    check_value(sda_drive_low, 1'b0, "target drives sda in write T-bit");
  endtask

  task automatic read_byte(output bus_byte_t data, input logic last);
    for (int i = 7; i >= 0; i--) begin
      @(posedge scl);
      data[i] = sda_bus;
    end
    @(negedge scl);
    check_value(rx_valid, 1'b0, "rx_valid in a read frame");
    check_value(busy, 1'b1, "busy during read byte");
    sda_ctrl = last;
    @(posedge scl);
    check_value(sda_drive_low, 1'b0, "target drives sda in read T-bit");
    @(negedge scl);
    sda_ctrl = 1'b1;
    check_value(busy, !last, "busy after read T-bit");
  endtask

  // one whole frame, model updated byte by byte
  task automatic run_frame(input logic [6:0] addr, input logic rnw, input int nbytes);
    logic      match;
    bus_byte_t got;
    match = (addr == OWN_ADDR);
    send_start();
    send_address(addr, rnw, match);
    if (!match) begin
      repeat (2) begin
        @(negedge scl);
        sda_ctrl = 1'b1;
        check_value(busy, 1'b0, "busy after address mismatch");
        check_value(rx_valid, 1'b0, "rx_valid after address mismatch");
      end
    end else if (rnw) begin
      for (int i = 0; i < nbytes; i++) begin
        read_byte(got, i == nbytes - 1);
        check_value(got, model_regs[model_ptr], "read data");
        model_ptr = (model_ptr + 1) % REG_COUNT;
      end
    end else begin
      for (int i = 0; i < nbytes; i++) begin
        write_byte(frame_buf[i], i == nbytes - 1);
        if (i == 0) begin
          model_ptr = int'(frame_buf[0]) % REG_COUNT;
        end else begin
          model_regs[model_ptr] = frame_buf[i];
          model_ptr = (model_ptr + 1) % REG_COUNT;
        end
      end
      @(negedge scl);
      sda_ctrl = 1'b1;
      check_value(busy, 1'b0, "busy after last write byte");
      check_value(rx_valid, 1'b0, "rx_valid after frame end");
    end
    @(negedge scl);  // idle gap before the next start
  endtask

  // **********************************************************************
  // test sequence
  // **********************************************************************

  initial begin
    logic rnw;
    logic [6:0] addr;
    int nbytes;
    void'($urandom(32'h8edc_928e));
    reset_n = 1'b0;
    sda_ctrl = 1'b1;
    for (int i = 0; i < REG_COUNT; i++) model_regs[i] = '0;
    model_ptr = 0;
    repeat (2) @(posedge scl);
    @(negedge scl);
    reset_n = 1'b1;

    repeat (3) begin
      @(negedge scl);
      check_value(busy, 1'b0, "busy after reset");
      check_value(rx_valid, 1'b0, "rx_valid after reset");
      check_value(sda_drive_low, 1'b0, "sda_drive_low after reset");
    end
    report_test("reset state");

    run_frame(wrong_address(), 1'($urandom), 2);
    fill_frame(bus_byte_t'($urandom), 2);
    run_frame(OWN_ADDR, 1'b0, 2);
    report_test("address filter");

    repeat (5) begin
      nbytes = 1 + $urandom_range(8, 1);  // pointer plus one to eight data bytes
      fill_frame(bus_byte_t'($urandom), nbytes);
      run_frame(OWN_ADDR, 1'b0, nbytes);
    end
    report_test("write receive");

    fill_frame(bus_byte_t'(REG_COUNT - 3), 7);  // runs past the last register
    run_frame(OWN_ADDR, 1'b0, 7);
    fill_frame(bus_byte_t'(REG_COUNT - 3), 1);
    run_frame(OWN_ADDR, 1'b0, 1);
    run_frame(OWN_ADDR, 1'b1, 6);
    report_test("read-back with wrap");

    run_frame(OWN_ADDR, 1'b1, 1);
    run_frame(OWN_ADDR, 1'b1, 3);
    run_frame(OWN_ADDR, 1'b1, 2);
    report_test("read termination");

    repeat (40) begin
      rnw = 1'($urandom);
      addr = (($urandom % 4) != 0) ? OWN_ADDR : wrong_address();
      if (rnw) begin
        run_frame(addr, 1'b1, $urandom_range(18, 1));
      end else begin
        nbytes = 1 + $urandom_range(8, 1);
        fill_frame(bus_byte_t'($urandom), nbytes);
        run_frame(addr, 1'b0, nbytes);
      end
    end
    report_test("random mix");

    $display("%0d tests, %0d checks, %0d errors", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- i3c_target_top.sv
// top level of the I3C target, wires the frame engine to the register bank; sda pin stays outside
`timescale 1ns/1ps
`default_nettype none

module i3c_target_top (
  input  logic                   scl,
  input  logic                   reset_n,
  input  logic                   sda_i,          // sampled bus level
  output logic                   sda_drive_low,  // open-drain pull
  output logic                   busy,
  output i3c_bus_pkg::bus_byte_t rx_data,
  output logic                   rx_valid
);

  // **********************************************************************
  // engine to bank strobes
  // **********************************************************************

  reg_access_if regs_if ();

  // **********************************************************************
  // frame engine
  // **********************************************************************

  i3c_target_fsm u_fsm (
    .scl           (scl),
    .reset_n       (reset_n),
    .sda_i         (sda_i),
    .sda_drive_low (sda_drive_low),
    .busy          (busy),
    .rx_data       (rx_data),
    .rx_valid      (rx_valid),
    .regs          (regs_if)
  );

  // **********************************************************************
  // register bank
  // **********************************************************************

  target_register_bank u_bank (
    .scl     (scl),
    .reset_n (reset_n),
    .regs    (regs_if)
  );

endmodule

`default_nettype wire

//--- reg_access_if.sv
// strobe interface from the frame engine to the register bank, instantiated in the top level
`timescale 1ns/1ps
`default_nettype none

interface reg_access_if;
  import target_regs_pkg::*;

  // single-cycle strobes, no handshake
  logic      ptr_load;  // low bits of wdata become the pointer
  logic      wr_en;     // store wdata, then pointer + 1
  reg_word_t wdata;
  logic      rd_next;   // pointer + 1

  reg_word_t rdata;     // register at the pointer

  modport engine (
    output ptr_load,
    output wr_en,
    output wdata,
    output rd_next,
    input  rdata
  );

  modport bank (
    input  ptr_load,
    input  wr_en,
    input  wdata,
    input  rd_next,
    output rdata
  );

endinterface

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build the I3C target testbench with Verilator, run it, and judge the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ_DIR=obj_dir
SIM_BIN=i3c_target_sim

verilator --binary --timing --assert -Wno-fatal \
  -f filelist.f \
  --top-module i3c_target_tb \
  -Mdir "$OBJ_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$OBJ_DIR/$SIM_BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi

echo "simulation clean, log in $LOG"
exit 0

//--- target_register_bank.sv
// register array with auto-incrementing pointer, fed by the frame engine through reg_access_if
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_config.svh"

module target_register_bank (
  input  logic       scl,
  input  logic       reset_n,
  reg_access_if.bank regs
);
  import target_regs_pkg::*;

  reg_word_t  regs_q [`I3C_REG_COUNT];
  reg_index_t ptr_q;

  // **********************************************************************
  // pointer and storage
  // **********************************************************************

  always_ff @(posedge scl or negedge reset_n) begin
    if (!reset_n) begin
      ptr_q <= '0;
      for (int i = 0; i < `I3C_REG_COUNT; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      if (regs.ptr_load) begin
        ptr_q <= regs.wdata[REG_IDX_W-1:0];  // first byte of a write
      end else if (regs.wr_en) begin
        regs_q[ptr_q] <= regs.wdata;
        ptr_q         <= ptr_q + 1'b1;  // wraps at the count
      end else if (regs.rd_next) begin
        ptr_q <= ptr_q + 1'b1;
      end
    end
  end

  // always the register under the pointer
  assign regs.rdata = regs_q[ptr_q];

  // pointer load only comes from write frames, rd_next only from reads
  a_no_load_on_read: assert property (
    @(posedge scl) disable iff (!reset_n)
    !(regs.ptr_load && regs.rd_next)
  );

endmodule

`default_nettype wire

//--- target_regs_pkg.sv
// register bank types, imported by the access interface, the bank and the frame engine
`default_nettype none

`include "i3c_target_config.svh"

package target_regs_pkg;

  // pointer width follows the register count
  localparam int REG_IDX_W = $clog2(`I3C_REG_COUNT);

  typedef logic [REG_IDX_W-1:0] reg_index_t;

  typedef logic [7:0] reg_word_t;  // one register

endpackage

`default_nettype wire
